//--- design/seg_params.svh
// Frame geometry, score format, class count and pipeline latency
// for the streaming class labeller

`ifndef SEG_PARAMS_SVH
`define SEG_PARAMS_SVH

// Frame size in pixels
`define SEG_WIDTH 8
`define SEG_HEIGHT 8

// Signed class score width
`define SEG_SCORE_W 13

// Number of classes per pixel
`define SEG_CLASSES 4

// Input strobe to output strobe
// Skip and pooled-frame RAM read (1) plus the class_select pipeline (3)
`define SEG_LATENCY 4

`endif

//--- design/seg_pkg.sv
// Shared types for the labeller: scores, labels and pixel coordinates

`include "seg_params.svh"

package seg_pkg;

    localparam int SCORE_W     = `SEG_SCORE_W;
    localparam int LABEL_W     = $clog2(`SEG_CLASSES);
    localparam int HCNT_W      = $clog2(`SEG_WIDTH);
    localparam int VCNT_W      = $clog2(`SEG_HEIGHT);
    localparam int HALF_HCNT_W = $clog2(`SEG_WIDTH / 2);
    localparam int HALF_VCNT_W = $clog2(`SEG_HEIGHT / 2);

    typedef logic signed [SCORE_W-1:0] score_t;

    // One score per class, class 0 in the low bits
    typedef struct packed {
        score_t [`SEG_CLASSES-1:0] cls;
    } scores_t;

    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [HCNT_W-1:0]  hcnt_t;
    typedef logic [VCNT_W-1:0]  vcnt_t;

    typedef struct packed {
        vcnt_t vcnt;
        hcnt_t hcnt;
    } pos_t;

    // Coordinates at half resolution
    typedef struct packed {
        logic [HALF_VCNT_W-1:0] vcnt;
        logic [HALF_HCNT_W-1:0] hcnt;
    } half_pos_t;

endpackage

//--- design/pixel_ram.sv
// Single-clock memory with read-first behaviour and a typed payload

`timescale 1ns/1ps

module pixel_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                     clock,
    input  logic                     write_enable,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  payload_t                 write_data,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    output payload_t                 read_data
);

    payload_t mem [DEPTH];

    // Same-address access returns the old word
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];
    end

    // Address from the caller's linearised coordinates must fit the array
    a_write_in_range : assert property (
        @(posedge clock) write_enable |-> (int'(write_addr) < DEPTH)
    ) else $error("pixel_ram write address %0d beyond depth %0d", write_addr, DEPTH);

endmodule

//--- design/max_pool.sv
// 2x2 max pooling of the class score stream, with a half-width
// line buffer holding the horizontal maxima of the even row

`timescale 1ns/1ps
`include "seg_params.svh"

module max_pool import seg_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      in_enable,
    input  pos_t      in_pos,
    input  scores_t   in_scores,
    output logic      pool_enable,
    output half_pos_t pool_pos,
    output scores_t   pool_scores
);

    localparam int LINE_DEPTH = `SEG_WIDTH / 2;

    scores_t even_col_scores;
    scores_t row_max;
    scores_t row_max_q;
    scores_t line_scores;
    logic    odd_col;
    logic    odd_row;

    // Per-class maximum of two score sets
    function automatic scores_t max_scores(scores_t a, scores_t b);
        scores_t m;
        for (int c = 0; c < `SEG_CLASSES; c++) begin
            m.cls[c] = (a.cls[c] > b.cls[c]) ? a.cls[c] : b.cls[c];
        end
        return m;
    endfunction

    assign odd_col = in_pos.hcnt[0];
    assign odd_row = in_pos.vcnt[0];
    assign row_max = max_scores(even_col_scores, in_scores);

    // -------------------------------------------------------------------------
    // Horizontal pair
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (in_enable && !odd_col) begin
            even_col_scores <= in_scores;
        end
        if (in_enable && odd_col) begin
            row_max_q <= row_max;
        end
    end

    // Even rows park their pair maxima, odd rows read them back
    pixel_ram #(
        .payload_t (scores_t),
        .DEPTH     (LINE_DEPTH)
    ) line_buf (
        .clock        (clock),
        .write_enable (in_enable && odd_col && !odd_row),
        .write_addr   (in_pos.hcnt[HCNT_W-1:1]),
        .write_data   (row_max),
        .read_addr    (in_pos.hcnt[HCNT_W-1:1]),
        .read_data    (line_scores)
    );

    // -------------------------------------------------------------------------
    // Block output, one cycle after the odd/odd strobe
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            pool_enable <= 1'b0;
        end else begin
            pool_enable <= in_enable && odd_col && odd_row;
        end
    end

    always_ff @(posedge clock) begin
        if (in_enable && odd_col && odd_row) begin
            pool_pos.vcnt <= in_pos.vcnt[VCNT_W-1:1];
            pool_pos.hcnt <= in_pos.hcnt[HCNT_W-1:1];
        end
    end

    // Both operands were captured on the same edge
    assign pool_scores = max_scores(row_max_q, line_scores);

    a_pos_in_frame : assert property (
        @(posedge clock) disable iff (reset)
        in_enable |-> (int'(in_pos.hcnt) < `SEG_WIDTH && int'(in_pos.vcnt) < `SEG_HEIGHT)
    ) else $error("max_pool strobe outside the frame at %0d,%0d", in_pos.vcnt, in_pos.hcnt);

endmodule

//--- design/unpool_stage.sv
// Pooled-frame store and nearest-neighbour upsampling read
// at the half position of the incoming pixel

`timescale 1ns/1ps
`include "seg_params.svh"

module unpool_stage import seg_pkg::*; (
    input  logic      clock,
    input  logic      pool_enable,
    input  half_pos_t pool_pos,
    input  scores_t   pool_scores,
    input  pos_t      in_pos,
    output scores_t   up_scores
);

    localparam int HALF_W = `SEG_WIDTH / 2;
    localparam int DEPTH  = HALF_W * (`SEG_HEIGHT / 2);
    localparam int ADDR_W = $clog2(DEPTH);

    half_pos_t          read_pos;
    logic [ADDR_W-1:0]  write_addr;
    logic [ADDR_W-1:0]  read_addr;

    // Every pixel of a 2x2 block maps to the same pooled entry
    assign read_pos.vcnt = in_pos.vcnt[VCNT_W-1:1];
    assign read_pos.hcnt = in_pos.hcnt[HCNT_W-1:1];

    // Row-major half-resolution address
    assign write_addr = ADDR_W'(int'(pool_pos.vcnt) * HALF_W + int'(pool_pos.hcnt));
    assign read_addr  = ADDR_W'(int'(read_pos.vcnt) * HALF_W + int'(read_pos.hcnt));

    // A block is rewritten only after its last read in the frame,
    // so reads return the previous frame
    pixel_ram #(
        .payload_t (scores_t),
        .DEPTH     (DEPTH)
    ) pooled_frame (
        .clock        (clock),
        .write_enable (pool_enable),
        .write_addr   (write_addr),
        .write_data   (pool_scores),
        .read_addr    (read_addr),
        .read_data    (up_scores)
    );

endmodule

//--- design/class_select.sv
// Saturating merge of skip and upsampled scores, then a two-level
// argmax with ties going to the lower class index

`timescale 1ns/1ps
`include "seg_params.svh"

module class_select import seg_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  scores_t skip_scores,
    input  scores_t up_scores,
    output label_t  label
);

    localparam score_t SCORE_MAX = {1'b0, {(SCORE_W-1){1'b1}}};
    localparam score_t SCORE_MIN = {1'b1, {(SCORE_W-1){1'b0}}};

    scores_t merged;
    score_t  lo_val;
    score_t  hi_val;
    label_t  lo_idx;
    label_t  hi_idx;

    // Overflow shows as a mismatch of the two top sum bits
    function automatic score_t sat_add(score_t a, score_t b);
        logic signed [SCORE_W:0] sum;
        sum = a + b;
        if (sum[SCORE_W] != sum[SCORE_W-1]) begin
            return sum[SCORE_W] ? SCORE_MIN : SCORE_MAX;
        end
        return sum[SCORE_W-1:0];
    endfunction

    // -------------------------------------------------------------------------
    // Stage 1 merge, stage 2 pairwise compare, stage 3 final compare
    // -------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            merged <= '0;
            lo_val <= '0;
            hi_val <= '0;
            lo_idx <= '0;
            hi_idx <= '0;
            label  <= '0;
        end else begin
            for (int c = 0; c < `SEG_CLASSES; c++) begin
                merged.cls[c] <= sat_add(skip_scores.cls[c], up_scores.cls[c]);
            end

            // Higher index wins only when strictly larger
            if (merged.cls[1] > merged.cls[0]) begin
                lo_val <= merged.cls[1];
                lo_idx <= label_t'(1);
            end else begin
                lo_val <= merged.cls[0];
                lo_idx <= label_t'(0);
            end
            if (merged.cls[3] > merged.cls[2]) begin
                hi_val <= merged.cls[3];
                hi_idx <= label_t'(3);
            end else begin
                hi_val <= merged.cls[2];
                hi_idx <= label_t'(2);
            end

            label <= (hi_val > lo_val) ? hi_idx : lo_idx;
        end
    end

    // Known scores in give a known label three stages later
    a_label_known : assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown($past({skip_scores, up_scores}, 3)) |-> !$isunknown(label)
    ) else $error("class_select label unknown after known input scores");

endmodule

//--- design/seg_top.sv
// Streaming labeller top: pooling, unpooling, skip buffer, merge and
// argmax, with frame-filled masking and the output delay line

`timescale 1ns/1ps
`include "seg_params.svh"

module seg_top import seg_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_enable,
    input  pos_t    in_pos,
    input  scores_t in_scores,
    output logic    out_enable,
    output pos_t    out_pos,
    output label_t  out_label
);

    localparam int SKIP_DEPTH = `SEG_WIDTH * `SEG_HEIGHT;
    localparam int SKIP_AW    = $clog2(SKIP_DEPTH);
    localparam pos_t LAST_POS = '{
        vcnt: vcnt_t'(`SEG_HEIGHT - 1),
        hcnt: hcnt_t'(`SEG_WIDTH - 1)
    };

    logic                    pool_enable;
    half_pos_t               pool_pos;
    scores_t                 pool_scores;
    scores_t                 up_scores;
    scores_t                 skip_scores;
    logic [SKIP_AW-1:0]      skip_addr;
    logic                    frame_filled;
    logic [`SEG_LATENCY-1:0] en_pipe;
    pos_t                    pos_pipe [`SEG_LATENCY];

    // -------------------------------------------------------------------------
    // Encoder side and its decoder counterpart
    // -------------------------------------------------------------------------
    max_pool pool (
        .clock       (clock),
        .reset       (reset),
        .in_enable   (in_enable),
        .in_pos      (in_pos),
        .in_scores   (in_scores),
        .pool_enable (pool_enable),
        .pool_pos    (pool_pos),
        .pool_scores (pool_scores)
    );

    unpool_stage unpool (
        .clock       (clock),
        .pool_enable (pool_enable),
        .pool_pos    (pool_pos),
        .pool_scores (pool_scores),
        .in_pos      (in_pos),
        .up_scores   (up_scores)
    );

    // Full-resolution skip path, read and rewritten at the same pixel
    assign skip_addr = SKIP_AW'(int'(in_pos.vcnt) * `SEG_WIDTH + int'(in_pos.hcnt));

    pixel_ram #(
        .payload_t (scores_t),
        .DEPTH     (SKIP_DEPTH)
    ) skip_buf (
        .clock        (clock),
        .write_enable (in_enable),
        .write_addr   (skip_addr),
        .write_data   (in_scores),
        .read_addr    (skip_addr),
        .read_data    (skip_scores)
    );

    class_select select (
        .clock       (clock),
        .reset       (reset),
        .skip_scores (skip_scores),
        .up_scores   (up_scores),
        .label       (out_label)
    );

    // -------------------------------------------------------------------------
    // Frame tracking and strobe alignment
    // -------------------------------------------------------------------------
    // No output until one whole frame sits in both RAMs
    always_ff @(posedge clock) begin
        if (reset) begin
            frame_filled <= 1'b0;
            en_pipe      <= '0;
        end else begin
            en_pipe <= {en_pipe[`SEG_LATENCY-2:0], in_enable & frame_filled};
            if (in_enable && in_pos == LAST_POS) begin
                frame_filled <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        pos_pipe[0] <= in_pos;
        for (int i = 1; i < `SEG_LATENCY; i++) begin
            pos_pipe[i] <= pos_pipe[i-1];
        end
    end

    assign out_enable = en_pipe[`SEG_LATENCY-1];
    assign out_pos    = pos_pipe[`SEG_LATENCY-1];

endmodule

//--- bench/seg_tb_model.svh
// Reference model of the labeller: 2x2 block maximum, nearest-neighbour
// repetition, saturating merge and argmax with ties to the lower index

`ifndef SEG_TB_MODEL_SVH
`define SEG_TB_MODEL_SVH

// Limits of a signed score
localparam int SAT_HI = (1 << (SCORE_W - 1)) - 1;
localparam int SAT_LO = -(1 << (SCORE_W - 1));

typedef scores_t frame_t [`SEG_HEIGHT][`SEG_WIDTH];

function automatic score_t ref_sat_add(input score_t a, input score_t b);
    int sum;
    sum = int'(a) + int'(b);
    if (sum > SAT_HI) begin
        sum = SAT_HI;
    end else if (sum < SAT_LO) begin
        sum = SAT_LO;
    end
    return score_t'(sum);
endfunction

// Per-class maximum over the 2x2 block at half position (bv, bh)
function automatic scores_t ref_block_max(input frame_t f, input int bv, input int bh);
    scores_t m;
    score_t  best;
    score_t  cand;
    for (int c = 0; c < `SEG_CLASSES; c++) begin
        best = f[2 * bv][2 * bh].cls[c];
        for (int dv = 0; dv < 2; dv++) begin
            for (int dh = 0; dh < 2; dh++) begin
                cand = f[2 * bv + dv][2 * bh + dh].cls[c];
                if (cand > best) begin
                    best = cand;
                end
            end
        end
        m.cls[c] = best;
    end
    return m;
endfunction

function automatic label_t ref_argmax(input scores_t s);
    label_t best;
    score_t best_val;
    score_t val;
    best     = '0;
    best_val = s.cls[0];
    for (int c = 1; c < `SEG_CLASSES; c++) begin
        val = s.cls[c];
        // Strictly larger only, a tie stays with the lower index
        if (val > best_val) begin
            best     = label_t'(c);
            best_val = val;
        end
    end
    return best;
endfunction

// Every pixel of a block sees that block's maximum
function automatic label_t ref_label(input frame_t f, input int v, input int h);
    scores_t up;
    scores_t merged;
    up = ref_block_max(f, v / 2, h / 2);
    for (int c = 0; c < `SEG_CLASSES; c++) begin
        merged.cls[c] = ref_sat_add(f[v][h].cls[c], up.cls[c]);
    end
    return ref_argmax(merged);
endfunction

`endif

//--- bench/seg_tb.sv
// Testbench for the streaming class labeller: random, saturating, tied
// and gapped frames checked against a reference model

`timescale 1ns/1ps
`include "seg_params.svh"

module seg_tb import seg_pkg::*; ();

    `include "seg_tb_model.svh"

    localparam int TIMEOUT_CYCLES = 100;
    localparam int KIND_RANDOM    = 0;
    localparam int KIND_EXTREME   = 1;
    localparam int KIND_FLAT      = 2;
    localparam int KIND_TIED      = 3;

    // One pending output and the edge its input was sampled on
    typedef struct packed {
        pos_t        pos;
        label_t      label;
        logic [31:0] cycle;
    } expect_t;

    logic    clock = 1'b0;
    logic    reset;
    logic    in_enable;
    pos_t    in_pos;
    scores_t in_scores;
    logic    out_enable;
    pos_t    out_pos;
    label_t  out_label;

    int      seed           = 32'hbdc7_b272;
    int      cycle_count    = 0;
    int      monitor_errors = 0;
    int      timeout_errors = 0;
    int      tests_passed   = 0;
    int      tests_failed   = 0;
    int      frames_seen    = 0;
    expect_t exp_q [$];
    frame_t  cur_frame;
    frame_t  prev_frame;

    seg_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .in_enable  (in_enable),
        .in_pos     (in_pos),
        .in_scores  (in_scores),
        .out_enable (out_enable),
        .out_pos    (out_pos),
        .out_label  (out_label)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------------------
    // Output comparison
    // ------------------------------------------------------------------------
    task automatic check_label(input label_t got, input label_t expected, input pos_t pos);
        if (got !== expected) begin
            $display("[FAIL] out_label got %h expected %h at out_pos %h", got, expected, pos);
            monitor_errors++;
        end
    endtask

    task automatic check_pos(input pos_t got, input pos_t expected);
        if (got !== expected) begin
            $display("[FAIL] out_pos got %h expected %h", got, expected);
            monitor_errors++;
        end
    endtask

    always @(posedge clock) begin
        expect_t e;
        if (!reset && out_enable === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("out_enable high at out_pos %h with no accepted input pending",
                         out_pos);
                monitor_errors++;
            end else begin
                e = exp_q.pop_front();
                check_pos(out_pos, e.pos);
                check_label(out_label, e.label, e.pos);
                if (cycle_count != int'(e.cycle) + `SEG_LATENCY) begin
                    $display("out_enable came %0d cycles after its input strobe, not %0d",
                             cycle_count - int'(e.cycle), `SEG_LATENCY);
                    monitor_errors++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic scores_t make_scores(input int kind);
        scores_t s;
        int      base;
        int      r;
        base = rand_below(2048) - 1024;
        for (int c = 0; c < `SEG_CLASSES; c++) begin
            r = $random(seed);
            case (kind)
                KIND_EXTREME: s.cls[c] = score_t'(r[0] ? SAT_HI - int'(r[4:1])
                                                       : SAT_LO + int'(r[4:1]));
                KIND_FLAT:    s.cls[c] = score_t'(base);
                KIND_TIED:    s.cls[c] = score_t'(r[0] ? base : base - 1 - int'(r[3:1]));
                default:      s.cls[c] = score_t'(r);
            endcase
        end
        return s;
    endfunction

    // Expected labels come from the frame streamed before this one
    task automatic stream_frame(input int kind, input int gap_pct);
        scores_t s;
        expect_t e;
        for (int v = 0; v < `SEG_HEIGHT; v++) begin
            for (int h = 0; h < `SEG_WIDTH; h++) begin
                s = make_scores(kind);
                for (int g = 0; g < 3 && rand_below(100) < gap_pct; g++) begin
                    @(posedge clock);
                    in_enable <= 1'b0;
                    in_scores <= make_scores(KIND_RANDOM);
                end
                @(posedge clock);
                in_enable   <= 1'b1;
                in_pos.vcnt <= vcnt_t'(v);
                in_pos.hcnt <= hcnt_t'(h);
                in_scores   <= s;
                if (frames_seen > 0) begin
                    e.pos.vcnt = vcnt_t'(v);
                    e.pos.hcnt = hcnt_t'(h);
                    e.label    = ref_label(prev_frame, v, h);
                    e.cycle    = 32'(cycle_count + 1);
                    exp_q.push_back(e);
                end
                cur_frame[v][h] = s;
            end
        end
        prev_frame = cur_frame;
        frames_seen++;
    endtask

    // Idle until every pending output has appeared, and a little beyond
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clock);
        in_enable <= 1'b0;
        while ((exp_q.size() != 0 || waited <= `SEG_LATENCY) && waited < TIMEOUT_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected outputs never appeared", exp_q.size());
            timeout_errors++;
        end
    endtask

    task automatic run_test(input string name, input int first_kind, input int next_kind,
                            input int frames, input int gap_pct);
        int errors_before;
        int errors;
        errors_before = monitor_errors + timeout_errors;
        for (int f = 0; f < frames; f++) begin
            stream_frame((f == 0) ? first_kind : next_kind, gap_pct);
        end
        wait_drain();
        errors = monitor_errors + timeout_errors - errors_before;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors);
        end
    endtask

    initial begin
        reset     = 1'b1;
        in_enable = 1'b0;
        in_pos    = '0;
        in_scores = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        run_test("first frame masked", KIND_RANDOM, KIND_RANDOM, 1, 0);
        run_test("random frames", KIND_RANDOM, KIND_RANDOM, 3, 0);
        run_test("raster order and latency", KIND_RANDOM, KIND_RANDOM, 1, 0);
        run_test("saturating sums", KIND_EXTREME, KIND_EXTREME, 2, 0);
        run_test("tied scores", KIND_FLAT, KIND_TIED, 2, 0);
        run_test("idle gaps", KIND_RANDOM, KIND_RANDOM, 2, 30);

        $display("%0d tests passed, %0d failed, %0d check errors", tests_passed,
                 tests_failed, monitor_errors + timeout_errors);
        if (tests_failed == 0 && monitor_errors + timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+design
+incdir+bench
design/seg_pkg.sv
design/pixel_ram.sv
design/max_pool.sv
design/unpool_stage.sv
design/class_select.sv
design/seg_top.sv
bench/seg_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the labeller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f project.f --top-module seg_tb -o seg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/seg_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
